// File: Makefile
# Verilator build for the PS/2 keyboard front end
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP ?= ps2_keyboard_tb
FILELIST ?= ps2_keyboard.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
SOURCES := $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/ps2_keyboard_tb.sv
// line timing assumes PS2_FILTER_LEN well below the 20 cycle hold and stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none
`include "ps2_keyboard_cfg.svh"

module ps2_keyboard_tb;
	localparam int lower_st = 0;                  // model states
	localparam int skip_st = 1;
	localparam int shift_st = 2;
	localparam int shift_brk_st = 3;
	localparam int caps_st = 4;
	localparam int caps_brk_st = 5;

	logic clk;
	logic reset;
	logic ps2c;
	logic ps2d;
	logic [7:0] scan_code;
	logic scan_code_ready;
	logic letter_case;
	logic [3:0] ship_control;
	logic [6:0] hex0;

	logic [31:0] lfsr = 32'd65606;                // random source state
	logic [7:0] expected[$];                      // accepted codes in order
	int seen = 0;                                 // pulses matched so far
	int m_state = lower_st;                       // reference model
	logic [7:0] m_shift_key = 8'h00;
	int m_caps_left = 0;
	logic m_case = 1'b0;
	logic [3:0] m_cmd = 4'd0;
	logic [6:0] m_seg = 7'h6b;
	logic [7:0] mapped_codes[9] = '{8'h1c, 8'h23, 8'h1b, 8'h1d, 8'h29, 8'h75, 8'h6b, 8'h72, 8'h74};
	logic [7:0] break_seq[8] = '{8'h1c, 8'hf0, 8'h23, 8'hf0, 8'h1d, 8'h29, 8'hf0, 8'h29};
	logic [7:0] shift_seq[13] = '{8'h12, 8'h1c, 8'hf0, 8'h1c, 8'h23, 8'hf0, 8'h12, 8'h1d,
		8'h59, 8'h29, 8'hf0, 8'h59, 8'h1b};
	logic [7:0] caps_seq[11] = '{8'h58, 8'h23, 8'hf0, 8'h58, 8'h58, 8'h1b, 8'hf0, 8'h1d,
		8'hf0, 8'h58, 8'h1c};

	ps2_keyboard_top dut0 (
		.clk(clk),
		.reset(reset),
		.ps2c(ps2c),
		.ps2d(ps2d),
		.scan_code(scan_code),
		.scan_code_ready(scan_code_ready),
		.letter_case(letter_case),
		.ship_control(ship_control),
		.hex0(hex0)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;               // 20 ns period
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("error %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "first mismatch");
		end
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 32'ha300_0000;
		return out;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < n; i++)
			r = {r[6:0], lfsr_bit()};
		return r;
	endfunction

	// mapped key or random byte, specials moved off by flipping bit 7
	function automatic logic [7:0] pick_code();
		logic [7:0] idx;
		logic [7:0] b;
		if (lfsr_bit())
		begin
			idx = rand_bits(4);
			return mapped_codes[(idx >= 8'd9) ? idx - 8'd9 : idx];
		end
		b = rand_bits(8);
		if (b == `PS2_BREAK_CODE || b == `PS2_LSHIFT_CODE || b == `PS2_RSHIFT_CODE ||
			b == `PS2_CAPS_CODE)
			b = b ^ 8'h80;
		return b;
	endfunction

	// expected keyboard behaviour, returns 1 when the code is accepted
	function automatic logic ref_key(input logic [7:0] code);
		logic acc;
		logic is_shift;
		logic is_caps;
		logic is_brk;
		acc = 1'b0;
		is_shift = (code == `PS2_LSHIFT_CODE) || (code == `PS2_RSHIFT_CODE);
		is_caps = (code == `PS2_CAPS_CODE);
		is_brk = (code == `PS2_BREAK_CODE);
		case (m_state)
			lower_st:
			begin
				if (is_shift)
				begin
					m_shift_key = code;
					m_state = shift_st;
				end
				else if (is_caps)
				begin
					m_caps_left = `PS2_CAPS_RELEASES;
					m_state = caps_st;
				end
				else if (is_brk)
					m_state = skip_st;
				else
					acc = 1'b1;
			end
			skip_st: m_state = lower_st;  // released key dropped
			shift_st:
			begin
				if (is_brk)
					m_state = shift_brk_st;
				else
					acc = !is_shift && !is_caps;
			end
			shift_brk_st: m_state = (code == m_shift_key) ? lower_st : shift_st;
			caps_st:
			begin
				if (is_caps)
					m_caps_left = m_caps_left - 1;
				else if (is_brk)
					m_state = caps_brk_st;
				else
					acc = !is_shift;
			end
			default:                      // caps_brk_st
			begin
				if (is_caps)
					m_caps_left = m_caps_left - 1;
				m_state = caps_st;
			end
		endcase
		if (m_state == caps_st && m_caps_left == 0)
			m_state = lower_st;           // third caps code ends caps mode
		m_case = (m_state == shift_st) || (m_state == caps_st);
		if (acc)
		begin
			case (code)
				8'h1c: m_cmd = 4'd1;
				8'h23: m_cmd = 4'd2;
				8'h1b: m_cmd = 4'd3;
				8'h1d: m_cmd = 4'd4;
				8'h29: m_cmd = 4'd5;
				8'h75: m_cmd = 4'd6;
				8'h6b: m_cmd = 4'd7;
				8'h72: m_cmd = 4'd8;
				8'h74: m_cmd = 4'd9;
				default: m_cmd = 4'd0;
			endcase
			case (m_cmd)
				4'd1: m_seg = 7'h5f;
				4'd2: m_seg = 7'h7d;
				4'd3: m_seg = 7'h3f;
				4'd4: m_seg = 7'h7e;
				4'd5: m_seg = 7'h77;
				default: m_seg = 7'h6b;
			endcase
		end
		return acc;
	endfunction

	task automatic idle_cycles(input int n);
		for (int c = 0; c < n; c++)
			@(negedge clk);
	endtask

	// one ps2c level for 20 cycles, optional opposite glitch from cycle 10
	task automatic drive_phase(input logic level, input int glitch);
		for (int c = 0; c < 20; c++)
		begin
			@(negedge clk);
			ps2c = (c >= 10 && c < 10 + glitch) ? ~level : level;
		end
	endtask

	task automatic send_frame(input logic [7:0] data, input int glitch);
		logic [10:0] bits;
		bits = {1'b1, ~^data, data, 1'b0};    // stop, odd parity, data, start
		for (int i = 0; i < 11; i++)
		begin
			ps2d = bits[i];               // data changes while ps2c is high or just before
			drive_phase(1'b1, glitch);
			drive_phase(1'b0, glitch);
		end
		ps2c = 1'b1;
		ps2d = 1'b1;
	endtask

	task automatic send_code(input logic [7:0] code, input int glitch);
		if (ref_key(code))
			expected.push_back(code);
		send_frame(code, glitch);
		idle_cycles(60);
		if (seen != expected.size())
			abort_run("no scan_code_ready pulse arrived for an accepted code");
		check_value("letter_case", 8'(letter_case), 8'(m_case));
		check_value("ship_control", 8'(ship_control), 8'(m_cmd));
		check_value("hex0", 8'(hex0), 8'(m_seg));
	endtask

	// compare process, every pulse must match the next accepted code
	always @(negedge clk)
	begin
		if (scan_code_ready)
		begin
			if (seen >= expected.size())
				abort_run("scan_code_ready pulsed when no code was expected");
			else
			begin
				check_value("scan_code", scan_code, expected[seen]);
				seen = seen + 1;
			end
		end
	end

	initial
	begin
		for (int c = 0; c < 200000; c++)
			@(posedge clk);
		abort_run("simulation did not finish within the cycle limit");
	end

	initial
	begin
		reset = 1'b1;
		ps2c = 1'b1;                          // idle line
		ps2d = 1'b1;
		idle_cycles(3);
		reset = 1'b0;
		idle_cycles(20);
		check_value("letter_case", 8'(letter_case), 8'h00);
		check_value("ship_control", 8'(ship_control), 8'h00);
		check_value("hex0", 8'(hex0), 8'h6b);
		check_value("scan_code", scan_code, 8'h00);
		for (int i = 0; i < 12; i++)
			send_code(pick_code(), 0);    // lowercase make codes
		foreach (break_seq[i])
			send_code(break_seq[i], 0);
		foreach (shift_seq[i])
			send_code(shift_seq[i], 0);
		foreach (caps_seq[i])
			send_code(caps_seq[i], 0);
		for (int i = 0; i < 4; i++)
			send_code(pick_code(), `PS2_FILTER_LEN - 1); // short ps2c glitches
		$display("TEST PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// File: ps2_keyboard.f
+incdir+src
src/ps2_keyboard_pkg.sv
src/ps2_frame_receiver.sv
src/key_state_tracker.sv
src/key_command_map.sv
src/ps2_keyboard_top.sv
dv/ps2_keyboard_tb.sv

// File: src/key_command_map.sv
// command holds until the next accepted code and any unlisted code clears it to none
`timescale 1ns/1ps
`default_nettype none

module key_command_map
(
	input wire clk,
	input wire reset,
	input wire code_ready,                            // sample scan_code this cycle
	input wire ps2_keyboard_pkg::scan_code_t scan_code,
	output ps2_keyboard_pkg::ship_cmd_t ship_control, // latched command
	output ps2_keyboard_pkg::seg_t hex0               // pattern, active low
);
	import ps2_keyboard_pkg::*;

	ship_cmd_t cmd_next;                              // command for the incoming code

	always_comb
	begin
		case (scan_code)
			8'h1c: cmd_next = 4'd1;           // a
			8'h23: cmd_next = 4'd2;           // d
			8'h1b: cmd_next = 4'd3;           // s
			8'h1d: cmd_next = 4'd4;           // w
			8'h29: cmd_next = 4'd5;           // space
			8'h75: cmd_next = 4'd6;           // up arrow
			8'h6b: cmd_next = 4'd7;           // left arrow
			8'h72: cmd_next = 4'd8;           // down arrow
			8'h74: cmd_next = 4'd9;           // right arrow
			default: cmd_next = 4'd0;         // none
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ship_control <= '0;
		else if (code_ready)
			ship_control <= cmd_next;
	end

	// arrows share the none pattern
	always_comb
	begin
		case (ship_control)
			4'd1: hex0 = 7'h5f;               // left
			4'd2: hex0 = 7'h7d;               // right
			4'd3: hex0 = 7'h3f;               // down
			4'd4: hex0 = 7'h7e;               // up
			4'd5: hex0 = 7'h77;               // fire
			default: hex0 = 7'h6b;            // idle pattern
		endcase
	end
endmodule

`default_nettype wire

// File: src/key_state_tracker.sv
// one pulse per code with no back-pressure and caps mode ends a cycle after the third caps code
`timescale 1ns/1ps
`default_nettype none
`include "ps2_keyboard_cfg.svh"

module key_state_tracker
(
	input wire clk,
	input wire reset,
	input wire frame_done,                            // new code from the receiver
	input wire ps2_keyboard_pkg::scan_code_t frame_data,
	output logic code_ready,                          // one cycle pulse per accepted make code
	output logic letter_case,                         // 1 for uppercase
	output ps2_keyboard_pkg::scan_code_t scan_code
);
	import ps2_keyboard_pkg::*;

	key_state_t state_reg;
	key_state_t state_next;
	scan_code_t shift_type_reg;                       // which shift key went down
	scan_code_t shift_type_next;
	caps_count_t caps_num_reg;                        // caps codes left to see
	caps_count_t caps_num_next;
	logic is_shift;                                   // either shift code
	logic is_caps;
	logic is_break;

	assign is_shift = (frame_data == `PS2_LSHIFT_CODE) || (frame_data == `PS2_RSHIFT_CODE);
	assign is_caps = (frame_data == `PS2_CAPS_CODE);
	assign is_break = (frame_data == `PS2_BREAK_CODE);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_reg <= st_lower;
			shift_type_reg <= '0;
			caps_num_reg <= '0;
		end
		else
		begin
			state_reg <= state_next;
			shift_type_reg <= shift_type_next;
			caps_num_reg <= caps_num_next;
		end
	end

	always_comb
	begin
		state_next = state_reg;                   // hold unless a code moves us
		shift_type_next = shift_type_reg;
		caps_num_next = caps_num_reg;
		code_ready = 1'b0;
		case (state_reg)
			st_lower:
			begin
				if (frame_done)
				begin
					if (is_shift)
					begin
						shift_type_next = frame_data; // remember for release
						state_next = st_shift;
					end
					else if (is_caps)
					begin
						caps_num_next = caps_count_t'(`PS2_CAPS_RELEASES);
						state_next = st_caps;
					end
					else if (is_break)
						state_next = st_skip_break;
					else
						code_ready = 1'b1; // plain make code
				end
			end
			st_skip_break:
			begin
				if (frame_done)           // released key code dropped
					state_next = st_lower;
			end
			st_shift:
			begin
				if (frame_done)
				begin
					if (is_break)
						state_next = st_shift_break;
					else if (!is_shift && !is_caps)
						code_ready = 1'b1; // shifted make code
				end
			end
			st_shift_break:
			begin
				if (frame_done)
				begin
					if (frame_data == shift_type_reg)
						state_next = st_lower; // shift released
					else
						state_next = st_shift; // other key released
				end
			end
			st_caps:
			begin
				if (caps_num_reg == '0)   // third caps code seen
					state_next = st_lower;
				if (frame_done)           // a code here still wins over the exit
				begin
					if (is_caps)
						caps_num_next = caps_num_reg - 1'b1;
					else if (is_break)
						state_next = st_caps_break;
					else if (!is_shift)
						code_ready = 1'b1;
				end
			end
			st_caps_break:
			begin
				if (frame_done)
				begin
					if (is_caps)      // caps key release counts too
						caps_num_next = caps_num_reg - 1'b1;
					state_next = st_caps;
				end
			end
			default:
				state_next = st_lower;    // unused encodings
		endcase
	end

	assign letter_case = (state_reg == st_shift) || (state_reg == st_caps); // not in break states
	assign scan_code = frame_data;                    // valid with code_ready only
endmodule

`default_nettype wire

// File: src/ps2_frame_receiver.sv
// ps2c only passes the glitch filter and parity and stop bits are shifted in but never checked
`timescale 1ns/1ps
`default_nettype none
`include "ps2_keyboard_cfg.svh"

module ps2_frame_receiver
#(
	parameter int filter_len = `PS2_FILTER_LEN        // samples needed to flip the clock level
)
(
	input wire clk,
	input wire reset,
	input wire ps2c,                                  // keyboard clock, async to clk
	input wire ps2d,                                  // keyboard data, async to clk
	output logic frame_done,                          // one cycle, frame_data valid
	output ps2_keyboard_pkg::scan_code_t frame_data   // received data byte
);
	import ps2_keyboard_pkg::*;

	logic [filter_len-1:0] filter_reg;                // ps2c sample history
	logic [filter_len-1:0] filter_next;
	logic f_val_reg;                                  // filtered ps2c level
	logic f_val_next;
	logic neg_edge;                                   // filtered clock falls this cycle
	rx_state_t state_reg;
	rx_state_t state_next;
	bit_count_t n_reg;                                // bits still to sample
	bit_count_t n_next;
	logic [`PS2_FRAME_BITS:0] d_reg;                  // frame shift register
	logic [`PS2_FRAME_BITS:0] d_next;

	assign filter_next = {ps2c, filter_reg[filter_len-1:1]}; // newest sample at msb

	// level changes only once the whole window agrees
	assign f_val_next = (filter_reg == '1) ? 1'b1 :
			(filter_reg == '0) ? 1'b0 :
			f_val_reg;                        // mixed window, hold

	assign neg_edge = f_val_reg & ~f_val_next;        // high now, low next

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			filter_reg <= '0;
			f_val_reg <= 1'b0;                // idle line pulls it high after filter_len cycles
		end
		else
		begin
			filter_reg <= filter_next;
			f_val_reg <= f_val_next;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state_reg <= rx_idle;
			n_reg <= '0;
			d_reg <= '0;                      // scan_code reads 0 after reset
		end
		else
		begin
			state_reg <= state_next;
			n_reg <= n_next;
			d_reg <= d_next;
		end
	end

	always_comb
	begin
		state_next = state_reg;                   // defaults hold everything
		n_next = n_reg;
		d_next = d_reg;
		frame_done = 1'b0;
		case (state_reg)
			rx_idle:
			begin
				if (neg_edge)             // start bit edge, ps2d not kept
				begin
					n_next = bit_count_t'(`PS2_FRAME_BITS);
					state_next = rx_shift;
				end
			end
			rx_shift:
			begin
				if (neg_edge)
				begin
					d_next = {ps2d, d_reg[`PS2_FRAME_BITS:1]}; // lsb first, shift right
					n_next = n_reg - 1'b1;
				end
				if (n_reg == '0)          // stop bit sampled last cycle
				begin
					frame_done = 1'b1;
					state_next = rx_idle;
				end
			end
		endcase
	end

	assign frame_data = d_reg[8:1];                   // bit 0 stale, 9 parity, 10 stop
endmodule

`default_nettype wire

// File: src/ps2_keyboard_cfg.svh
// timing values assume a clk much faster than the ps2c line, about 50 MHz against 10 to 17 kHz
`ifndef PS2_KEYBOARD_CFG_SVH
`define PS2_KEYBOARD_CFG_SVH

// receiver
`define PS2_FILTER_LEN 8      // equal ps2c samples before the filtered clock flips
`define PS2_FRAME_BITS 10     // edges after start: 8 data, parity, stop

// special scan codes
`define PS2_BREAK_CODE 8'hf0  // key released prefix
`define PS2_LSHIFT_CODE 8'h12 // left shift
`define PS2_RSHIFT_CODE 8'h59 // right shift
`define PS2_CAPS_CODE 8'h58   // caps lock

// caps lock tracking
// a caps press and release gives caps, f0, caps
// so three caps codes are counted before lowercase again
`define PS2_CAPS_RELEASES 3   // caps counter reload



`endif

// File: src/ps2_keyboard_pkg.sv
// types only and widths here must agree with the define values in the config header
`default_nettype none

package ps2_keyboard_pkg;

	typedef logic [7:0] scan_code_t;   // one keyboard scan code
	typedef logic [3:0] bit_count_t;   // frame bits still to sample
	typedef logic [1:0] caps_count_t;  // caps codes left before lowercase
	typedef logic [3:0] ship_cmd_t;    // ship command, 0 is none
	typedef logic [6:0] seg_t;         // seven segment, active low

	// frame receiver FSM
	typedef enum logic
	{
		rx_idle,                   // waiting for start bit edge
		rx_shift                   // sampling data, parity, stop
	} rx_state_t;

	// key state tracker FSM
	typedef enum logic [2:0]
	{
		st_lower,                  // plain keys, lowercase
		st_skip_break,             // drop the code after f0
		st_shift,                  // shift held
		st_shift_break,            // f0 seen while shifted
		st_caps,                   // caps lock active
		st_caps_break              // f0 seen in caps mode
	} key_state_t;



endpackage

`default_nettype wire

// File: src/ps2_keyboard_top.sv
// ps2c and ps2d go straight into the receiver filter and reset is asynchronous active high
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_top
(
	input wire clk,
	input wire reset,
	input wire ps2c,                                  // keyboard clock line
	input wire ps2d,                                  // keyboard data line
	output ps2_keyboard_pkg::scan_code_t scan_code,   // valid with scan_code_ready
	output logic scan_code_ready,                     // one cycle per accepted make code
	output logic letter_case,                         // shift or caps active
	output ps2_keyboard_pkg::ship_cmd_t ship_control,
	output ps2_keyboard_pkg::seg_t hex0
);
	import ps2_keyboard_pkg::*;

	logic frame_done;                                 // receiver to tracker pulse
	scan_code_t frame_data;

	ps2_frame_receiver rx0 (
		.clk(clk),
		.reset(reset),
		.ps2c(ps2c),
		.ps2d(ps2d),
		.frame_done(frame_done),
		.frame_data(frame_data)
	);

	key_state_tracker trk0 (
		.clk(clk),
		.reset(reset),
		.frame_done(frame_done),
		.frame_data(frame_data),
		.code_ready(scan_code_ready),
		.letter_case(letter_case),
		.scan_code(scan_code)
	);

	key_command_map map0 (
		.clk(clk),
		.reset(reset),
		.code_ready(scan_code_ready),
		.scan_code(scan_code),
		.ship_control(ship_control),
		.hex0(hex0)
	);
endmodule

`default_nettype wire
